// ==== div_consts.svh ====
// divider constants, operand width and shift-subtract step count
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// width of one operand, quotient or remainder
`define DIV_WIDTH 32

// one restoring step per quotient bit
`define DIV_STEPS 32

`endif

// ==== div_pkg.sv ====
// divider types, word and result vectors plus the control state encoding
`include "div_consts.svh"

package div_pkg;

	// dividend, divisor, quotient or remainder
	typedef logic [`DIV_WIDTH-1:0] word_t;

	// {remainder, quotient}, also the width of the working register
	typedef logic [2*`DIV_WIDTH-1:0] dword_t;

	// wide enough to hold DIV_STEPS itself
	typedef logic [$clog2(`DIV_STEPS):0] step_t;

	typedef enum logic [1:0] {
		DIV_IDLE    = 2'b00,
		DIV_BY_ZERO = 2'b01,
		DIV_RUN     = 2'b10,
		DIV_END     = 2'b11
	} div_state_e;

endpackage

// ==== div_fsm.sv ====
// divider control FSM, sequences load, step, finish and ready and handles annul
`timescale 1ns/1ns

module div_fsm (
	input  logic          clk,
	input  logic          reset_i,
	input  logic          start_i,
	input  logic          annul_i,
	input  div_pkg::word_t opdata2_i,
	input  logic          last_step_i,
	output logic          load_o,
	output logic          load_zero_o,
	output logic          step_en_o,
	output logic          finish_o,
	output logic          clear_o,
	output logic          ready_o
);
	import div_pkg::*;

	div_state_e state_q;
	div_state_e state_d;
	logic       divisor_zero;
	logic       accept;
	logic       ready_q;

	// starts only count while idle
	assign accept       = (state_q == DIV_IDLE) && start_i;
	assign divisor_zero = (opdata2_i == '0);

	assign load_o      = accept && !divisor_zero;
	assign load_zero_o = accept && divisor_zero;
	assign step_en_o   = (state_q == DIV_RUN);
	assign finish_o    = (state_q == DIV_END);
	// an annulled zero-divisor op leaves the result untouched
	assign clear_o     = (state_q == DIV_BY_ZERO) && !annul_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			DIV_IDLE: begin
				if (start_i) begin
					state_d = divisor_zero ? DIV_BY_ZERO : DIV_RUN;
				end
			end
			DIV_BY_ZERO: state_d = DIV_IDLE;
			DIV_RUN: begin
				// annul wins over a coinciding last step
				if (annul_i) begin
					state_d = DIV_IDLE;
				end else if (last_step_i) begin
					state_d = DIV_END;
				end
			end
			DIV_END: state_d = DIV_IDLE;
			default: state_d = DIV_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= DIV_IDLE;
			ready_q <= 1'b0;
		end else begin
			state_q <= state_d;
			ready_q <= finish_o || clear_o;
		end
	end

	assign ready_o = ready_q;

	// one completion pulse per operation
	ready_single_pulse: assert property (@(posedge clk) disable iff (reset_i)
		ready_o |=> !ready_o);

	// steps only inside a run opened by a nonzero-divisor load
	step_only_in_run: assert property (@(posedge clk) disable iff (reset_i)
		step_en_o |-> $past(load_o || step_en_o));

endmodule

// ==== div_step_counter.sv ====
// step counter for the shift-subtract loop, flags the final step
`timescale 1ns/1ns
`include "div_consts.svh"

module div_step_counter (
	input  logic clk,
	input  logic reset_i,
	input  logic load_i,
	input  logic load_zero_i,
	input  logic step_en_i,
	output logic last_step_o
);
	import div_pkg::*;

	step_t count_q;

	always_ff @(posedge clk) begin
		if (reset_i || load_i || load_zero_i) begin
			count_q <= '0;
		end else if (step_en_i) begin
			count_q <= count_q + step_t'(1);
		end
	end

	// high during the step that produces the last quotient bit
	assign last_step_o = (count_q == step_t'(`DIV_STEPS - 1));

	// the FSM must leave RUN before the count overshoots
	count_in_range: assert property (@(posedge clk) disable iff (reset_i)
		count_q <= step_t'(`DIV_STEPS));

endmodule

// ==== div_shift_sub.sv ====
// restoring divider datapath, operand magnitudes and one shift-subtract per cycle
`timescale 1ns/1ns
`include "div_consts.svh"

module div_shift_sub (
	input  logic           clk,
	input  logic           reset_i,
	input  logic           load_i,
	input  logic           load_zero_i,
	input  logic           step_en_i,
	input  logic           signed_div_i,
	input  div_pkg::word_t opdata1_i,
	input  div_pkg::word_t opdata2_i,
	output div_pkg::word_t quotient_o,
	output div_pkg::word_t remainder_o
);
	import div_pkg::*;

	// upper half partial remainder, lower half dividend bits then quotient bits
	dword_t work_q;
	word_t  divisor_q;

	word_t dividend_mag;
	word_t divisor_mag;

	// partial remainder shifted left with the next dividend bit, one bit wider
	logic [`DIV_WIDTH:0]   partial;
	logic [`DIV_WIDTH+1:0] diff;
	logic                  fits;
	dword_t                work_next;

	// two's complement magnitude, the most negative value maps onto itself
	always_comb begin
		dividend_mag = opdata1_i;
		divisor_mag  = opdata2_i;
		if (signed_div_i && opdata1_i[`DIV_WIDTH-1]) begin
			dividend_mag = word_t'(~opdata1_i + word_t'(1));
		end
		if (signed_div_i && opdata2_i[`DIV_WIDTH-1]) begin
			divisor_mag = word_t'(~opdata2_i + word_t'(1));
		end
	end

	always_comb begin
		partial = work_q[2*`DIV_WIDTH-1:`DIV_WIDTH-1];
		diff    = {1'b0, partial} - {2'b00, divisor_q};
		fits    = !diff[`DIV_WIDTH+1];
		if (fits) begin
			work_next = {diff[`DIV_WIDTH-1:0], work_q[`DIV_WIDTH-2:0], 1'b1};
		end else begin
			// restore, partial is below the divisor so its top bit is zero
			work_next = {partial[`DIV_WIDTH-1:0], work_q[`DIV_WIDTH-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i || load_zero_i) begin
			work_q <= '0;
		end else if (load_i) begin
			work_q <= {word_t'(0), dividend_mag};
		end else if (step_en_i) begin
			work_q <= work_next;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			divisor_q <= divisor_mag;
		end
	end

	assign quotient_o  = work_q[`DIV_WIDTH-1:0];
	assign remainder_o = work_q[2*`DIV_WIDTH-1:`DIV_WIDTH];

endmodule

// ==== div_result_fix.sv ====
// sign correction of quotient and remainder, holds the last completed result
`timescale 1ns/1ns
`include "div_consts.svh"

module div_result_fix (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            load_i,
	input  logic            load_zero_i,
	input  logic            signed_div_i,
	input  logic            dividend_sign_i,
	input  logic            divisor_sign_i,
	input  logic            finish_i,
	input  logic            clear_i,
	input  div_pkg::word_t  quotient_i,
	input  div_pkg::word_t  remainder_i,
	output div_pkg::dword_t result_o
);
	import div_pkg::*;

	logic   neg_quot_q;
	logic   neg_rem_q;
	word_t  quot_fixed;
	word_t  rem_fixed;
	dword_t result_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			neg_quot_q <= 1'b0;
			neg_rem_q  <= 1'b0;
		end else if (load_i || load_zero_i) begin
			// quotient negative when signs differ, remainder follows the dividend
			neg_quot_q <= signed_div_i && (dividend_sign_i ^ divisor_sign_i);
			neg_rem_q  <= signed_div_i && dividend_sign_i;
		end
	end

	assign quot_fixed = neg_quot_q ? word_t'(~quotient_i + word_t'(1)) : quotient_i;
	assign rem_fixed  = neg_rem_q ? word_t'(~remainder_i + word_t'(1)) : remainder_i;

	always_ff @(posedge clk) begin
		if (reset_i || clear_i) begin
			result_q <= '0;
		end else if (finish_i) begin
			result_q <= {rem_fixed, quot_fixed};
		end
	end

	assign result_o = result_q;

endmodule

// ==== div_unit.sv ====
// multi-cycle integer divider, control FSM with step counter and datapath
`timescale 1ns/1ns
`include "div_consts.svh"

module div_unit (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            signed_div_i,
	input  logic            start_i,
	input  logic            annul_i,
	input  div_pkg::word_t  opdata1_i,
	input  div_pkg::word_t  opdata2_i,
	output div_pkg::dword_t result_o,
	output logic            ready_o
);
	import div_pkg::*;

	logic  load;
	logic  load_zero;
	logic  step_en;
	logic  finish;
	logic  clear;
	logic  last_step;
	word_t quotient;
	word_t remainder;

	div_fsm fsm_inst (
		.clk         (clk),
		.reset_i     (reset_i),
		.start_i     (start_i),
		.annul_i     (annul_i),
		.opdata2_i   (opdata2_i),
		.last_step_i (last_step),
		.load_o      (load),
		.load_zero_o (load_zero),
		.step_en_o   (step_en),
		.finish_o    (finish),
		.clear_o     (clear),
		.ready_o     (ready_o)
	);

	div_step_counter step_counter_inst (
		.clk         (clk),
		.reset_i     (reset_i),
		.load_i      (load),
		.load_zero_i (load_zero),
		.step_en_i   (step_en),
		.last_step_o (last_step)
	);

	div_shift_sub shift_sub_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.load_i       (load),
		.load_zero_i  (load_zero),
		.step_en_i    (step_en),
		.signed_div_i (signed_div_i),
		.opdata1_i    (opdata1_i),
		.opdata2_i    (opdata2_i),
		.quotient_o   (quotient),
		.remainder_o  (remainder)
	);

	// operand sign bits go straight to the correction stage
	div_result_fix result_fix_inst (
		.clk             (clk),
		.reset_i         (reset_i),
		.load_i          (load),
		.load_zero_i     (load_zero),
		.signed_div_i    (signed_div_i),
		.dividend_sign_i (opdata1_i[`DIV_WIDTH-1]),
		.divisor_sign_i  (opdata2_i[`DIV_WIDTH-1]),
		.finish_i        (finish),
		.clear_i         (clear),
		.quotient_i      (quotient),
		.remainder_i     (remainder),
		.result_o        (result_o)
	);

endmodule

// ==== tb_div_unit.sv ====
// self-checking testbench for the multi-cycle divider, reference model, assertions and watchdog
`timescale 1ns/1ns
`include "div_consts.svh"

module tb_div_unit;
	import div_pkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 5;
	localparam int RUN_LATENCY   = `DIV_STEPS + 2;
	localparam int ZERO_LATENCY  = 2;
	localparam int N_UNSIGNED    = 24;
	localparam int N_CORNER      = 20;
	localparam int N_SIGNED      = 16;
	localparam int N_ZERO        = 4;
	localparam int N_ANNUL       = 6;
	localparam int N_IGNORED     = 2;
	localparam int NUM_OPS       = N_UNSIGNED + N_CORNER + N_SIGNED + N_ZERO + N_ANNUL + N_IGNORED;
	localparam int CYCLES_PER_OP = 40;
	localparam int WATCHDOG_NS   = (RESET_CYCLES + CYCLES_PER_OP * NUM_OPS) * CLK_PERIOD;

	logic   clk;
	logic   reset_i;
	logic   signed_div_i;
	logic   start_i;
	logic   annul_i;
	word_t  opdata1_i;
	word_t  opdata2_i;
	dword_t result_o;
	logic   ready_o;

	// model of the operation in flight
	logic   model_busy;
	logic   model_started;
	int     model_cnt;
	int     model_lat;
	dword_t exp_result;
	logic   done_due;
	logic   annul_honoured;

	int ready_count;
	int expect_count;

	div_unit div_unit_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.signed_div_i (signed_div_i),
		.start_i      (start_i),
		.annul_i      (annul_i),
		.opdata1_i    (opdata1_i),
		.opdata2_i    (opdata2_i),
		.result_o     (result_o),
		.ready_o      (ready_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// truncating division, remainder takes the sign of the dividend
	function automatic dword_t expected_result(input logic signed_mode, input word_t a,
			input word_t b);
		longint          sa;
		longint          sb;
		longint unsigned ua;
		longint unsigned ub;
		word_t           q;
		word_t           r;
		if (b == '0) begin
			return '0;
		end
		if (signed_mode) begin
			// 64-bit math keeps the most negative over -1 well defined
			sa = longint'($signed(a));
			sb = longint'($signed(b));
			q  = word_t'(sa / sb);
			r  = word_t'(sa % sb);
		end else begin
			ua = {32'b0, a};
			ub = {32'b0, b};
			q  = word_t'(ua / ub);
			r  = word_t'(ua % ub);
		end
		return {r, q};
	endfunction

	task automatic report_error_and_stop(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// ready due exactly at the latency edge, annul honoured in RUN and BY_ZERO
	assign done_due       = model_busy && (model_cnt == model_lat);
	assign annul_honoured = model_busy && annul_i &&
		((model_lat == ZERO_LATENCY) ? (model_cnt == 1) : (model_cnt <= model_lat - 2));

	always @(posedge clk) begin
		if (reset_i) begin
			model_busy    <= 1'b0;
			model_started <= 1'b0;
			model_cnt     <= 0;
			model_lat     <= 0;
			exp_result    <= '0;
		end else begin
			if (model_busy) begin
				model_cnt <= model_cnt + 1;
			end
			if (done_due || annul_honoured) begin
				model_busy <= 1'b0;
			end
			// starts count only when the unit is idle on this edge
			if (start_i && (!model_busy || done_due)) begin
				model_busy    <= 1'b1;
				model_started <= 1'b1;
				model_cnt     <= 1;
				model_lat     <= (opdata2_i == '0) ? ZERO_LATENCY : RUN_LATENCY;
				exp_result    <= expected_result(signed_div_i, opdata1_i, opdata2_i);
			end
		end
	end

	always @(posedge clk) begin
		if (reset_i) begin
			ready_count <= 0;
		end else if (ready_o) begin
			ready_count <= ready_count + 1;
		end
	end

	ready_on_time: assert property (@(posedge clk) disable iff (reset_i)
		ready_o == done_due)
		else report_error_and_stop($sformatf("Mismatch at %0t: ready_o %b, expected %b",
			$time, $sampled(ready_o), $sampled(done_due)));

	result_matches: assert property (@(posedge clk) disable iff (reset_i)
		ready_o |-> result_o == exp_result)
		else report_error_and_stop($sformatf("Mismatch at %0t: result_o %h, expected %h",
			$time, $sampled(result_o), $sampled(exp_result)));

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset_i)
		!model_started |-> (!ready_o && result_o == '0))
		else report_error_and_stop($sformatf("Mismatch at %0t: activity before first start",
			$time));

	idle_state_tracks: assert property (@(posedge clk) disable iff (reset_i)
		(!model_busy || done_due) == (div_unit_inst.fsm_inst.state_q == DIV_IDLE))
		else report_error_and_stop($sformatf("Mismatch at %0t: FSM idle state disagrees",
			$time));

	task automatic pulse_start(input logic signed_mode, input word_t a, input word_t b);
		signed_div_i = signed_mode;
		opdata1_i    = a;
		opdata2_i    = b;
		start_i      = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready_o) begin
			@(negedge clk);
		end
	endtask

	task automatic run_division(input logic signed_mode, input word_t a, input word_t b);
		pulse_start(signed_mode, a, b);
		wait_ready();
		expect_count++;
	endtask

	task automatic run_both_modes(input word_t a, input word_t b);
		run_division(1'b1, a, b);
		run_division(1'b0, a, b);
	endtask

	// annul seen on the given edge after the accepting one
	task automatic run_annulled(input logic signed_mode, input word_t a, input word_t b,
			input int annul_edge, input logic completes);
		pulse_start(signed_mode, a, b);
		repeat (annul_edge - 1) @(negedge clk);
		annul_i = 1'b1;
		@(negedge clk);
		annul_i = 1'b0;
		repeat (CYCLES_PER_OP) @(negedge clk);
		if (completes) begin
			expect_count++;
		end
	endtask

	task automatic run_with_ignored_start(input word_t a, input word_t b, input word_t a2,
			input word_t b2);
		pulse_start(1'b0, a, b);
		repeat (10) @(negedge clk);
		pulse_start(1'b1, a2, b2);
		wait_ready();
		expect_count++;
		// no second ready may follow
		repeat (CYCLES_PER_OP) @(negedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_error_and_stop("timeout: the divider did not finish within the allowed time");
	end

	initial begin
		word_t a;
		word_t b;
		void'($urandom(32'h5d521749));
		clk          = 1'b0;
		reset_i      = 1'b1;
		signed_div_i = 1'b0;
		start_i      = 1'b0;
		annul_i      = 1'b0;
		opdata1_i    = '0;
		opdata2_i    = '0;
		expect_count = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset_i = 1'b0;
		repeat (8) @(negedge clk);

		for (int i = 0; i < N_UNSIGNED; i++) begin
			a = $urandom;
			b = $urandom >> ($urandom % 32);
			run_division(1'b0, a, b);
		end

		// sign combinations and the overflow corner
		run_both_modes(32'h8000_0000, 32'hFFFF_FFFF);
		run_both_modes(32'h8000_0000, 32'h0000_0001);
		run_both_modes(32'hFFFF_FFFF, 32'h0000_0001);
		run_both_modes(32'h0000_0001, 32'hFFFF_FFFF);
		run_both_modes(32'h0000_0007, 32'h0000_0002);
		run_both_modes(32'hFFFF_FFF9, 32'h0000_0002);
		run_both_modes(32'h0000_0007, 32'hFFFF_FFFE);
		run_both_modes(32'hFFFF_FFF9, 32'hFFFF_FFFE);
		run_both_modes(32'h8000_0000, 32'h8000_0000);
		run_both_modes(32'h0000_0005, 32'h8000_0000);

		for (int i = 0; i < N_SIGNED; i++) begin
			a = $urandom;
			b = $urandom >> ($urandom % 31);
			if ($urandom % 2 == 1) begin
				b = ~b + word_t'(1);
			end
			run_division(1'b1, a, b);
		end

		run_division(1'b0, 32'h1234_5678, '0);
		run_division(1'b1, 32'h8000_0000, '0);
		run_division(1'b1, 32'hFFFF_FFFF, '0);
		run_division(1'b0, '0, '0);

		// mid-run, zero-divisor and end-state annul
		run_annulled(1'b0, 32'hDEAD_BEEF, 32'h0000_0123, 5, 1'b0);
		run_division(1'b0, 32'hDEAD_BEEF, 32'h0000_0123);
		run_annulled(1'b1, 32'h0000_0042, '0, 1, 1'b0);
		run_division(1'b1, 32'hFFFF_FF00, 32'h0000_0010);
		run_annulled(1'b1, 32'h8765_4321, 32'h0000_0007, RUN_LATENCY - 1, 1'b1);
		run_division(1'b1, 32'h8765_4321, 32'hFFFF_FFF9);

		run_with_ignored_start(32'hCAFE_F00D, 32'h0000_0333, 32'h0000_0010, '0);

		repeat (4) @(negedge clk);
		if (ready_count != expect_count) begin
			report_error_and_stop($sformatf("ready pulse count %0d differs from the %0d expected",
				ready_count, expect_count));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== list.f ====
+incdir+.
div_pkg.sv
div_fsm.sv
div_step_counter.sv
div_shift_sub.sv
div_result_fix.sv
div_unit.sv
tb_div_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_div_unit \
	--Mdir obj_dir -o tb_div_unit_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_div_unit_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
